// File: hdl/rrag_pkg.sv
package rrag_pkg;

    localparam int num_gpr = 8;
    localparam int gpr_aw  = 3;
    localparam int data_w  = 32;
    localparam int num_seg = 4;
    localparam int limit_w = 20;
    localparam int addr16_w = 16;  // offset width in 16-bit addressing
    localparam int wb_aw   = 4;

    localparam logic [wb_aw-1:0] wb_lim_base  = 4'd4;  // first limit word
    localparam logic [wb_aw-1:0] wb_ctrl_addr = 4'd8;  // bit 0 selects 32-bit addressing

    typedef enum logic [1:0] {size_byte, size_word, size_dword, size_qword} opsize_e;

    typedef enum logic [1:0] {seg_es, seg_cs, seg_ss, seg_ds} seg_e;

    typedef struct packed {
        logic              valid;
        logic [gpr_aw-1:0] base_reg;
        logic [gpr_aw-1:0] index_reg;
        logic              use_base;
        logic              use_index;
        logic [1:0]        scale;     // index is shifted left by this amount
        seg_e              seg;
        logic [data_w-1:0] disp;
        opsize_e           opsize;
        logic [gpr_aw-1:0] dest_reg;
        logic              dest_ld;
    } uop_t;

    typedef struct packed {
        logic              valid;
        logic [gpr_aw-1:0] reg_addr;
        logic [data_w-1:0] data;
    } res_wr_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] base_val;
        logic [data_w-1:0] index_val;
        logic [data_w-1:0] lin_addr;
        logic              fault;
        logic [gpr_aw-1:0] dest_reg;
        logic              dest_ld;
        opsize_e           opsize;
    } agu_out_t;

    typedef struct packed {
        logic [num_seg-1:0][data_w-1:0]  base;
        logic [num_seg-1:0][limit_w-1:0] limit;
        logic                            addr32;
    } seg_cfg_t;

endpackage

// File: hdl/gpr_file.sv
`timescale 1ns/1ps

module gpr_file (
    input  logic                            clk,
    input  logic                            arst_n,
    input  rrag_pkg::res_wr_t               res_wr,
    input  logic [rrag_pkg::gpr_aw-1:0]     rd_addr_a,
    input  logic [rrag_pkg::gpr_aw-1:0]     rd_addr_b,
    output logic [rrag_pkg::data_w-1:0]     rd_data_a,
    output logic [rrag_pkg::data_w-1:0]     rd_data_b,
    output logic                            rd_pend_a,
    output logic                            rd_pend_b,
    input  logic                            mark_en,
    input  logic [rrag_pkg::gpr_aw-1:0]     mark_addr
);
    import rrag_pkg::*;

    logic [data_w-1:0]  regs [num_gpr];
    logic [num_gpr-1:0] pend;  // set while an older micro-op still owes this register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_gpr; i++) begin
                regs[i] <= '0;
            end
        end else if (res_wr.valid) begin
            regs[res_wr.reg_addr] <= res_wr.data;
        end
    end

    // the write-back clears a pending bit, but a new claim on the same edge keeps it set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend <= '0;
        end else begin
            if (res_wr.valid) begin
                pend[res_wr.reg_addr] <= 1'b0;
            end
            if (mark_en) begin
                pend[mark_addr] <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_data_a = regs[rd_addr_a];  // old value during a same-cycle write
        rd_data_b = regs[rd_addr_b];
        rd_pend_a = pend[rd_addr_a];
        rd_pend_b = pend[rd_addr_b];
    end

endmodule

// File: hdl/seg_cfg_regs.sv
`timescale 1ns/1ps

module seg_cfg_regs (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [rrag_pkg::wb_aw-1:0]     wb_adr,
    input  logic [rrag_pkg::data_w-1:0]    wb_dat_w,
    output logic [rrag_pkg::data_w-1:0]    wb_dat_r,
    output logic                           wb_ack,
    output rrag_pkg::seg_cfg_t             cfg
);
    import rrag_pkg::*;

    logic [num_seg-1:0][data_w-1:0]  base_q;
    logic [num_seg-1:0][limit_w-1:0] limit_q;
    logic                            addr32_q;
    logic                            wb_req;
    logic                            is_base;
    logic                            is_lim;
    logic                            is_ctrl;
    logic [$clog2(num_seg)-1:0]      slot;

    assign wb_req  = wb_cyc & wb_stb & ~wb_ack;  // new access, not yet acknowledged
    assign is_base = (wb_adr < num_seg);
    assign is_lim  = (wb_adr >= wb_lim_base) && (wb_adr < wb_lim_base + num_seg);
    assign is_ctrl = (wb_adr == wb_ctrl_addr);
    assign slot    = wb_adr[$clog2(num_seg)-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            base_q   <= '0;
            limit_q  <= '0;
            addr32_q <= 1'b1;  // comes up in 32-bit addressing
        end else if (wb_req && wb_we) begin
            if (is_base) begin
                base_q[slot] <= wb_dat_w;
            end
            if (is_lim) begin
                limit_q[slot] <= wb_dat_w[limit_w-1:0];
            end
            if (is_ctrl) begin
                addr32_q <= wb_dat_w[0];
            end
        end
    end

    // address is held by the master through the ack cycle
    always_comb begin
        wb_dat_r = '0;
        if (is_base) begin
            wb_dat_r = base_q[slot];
        end else if (is_lim) begin
            wb_dat_r = {{(data_w-limit_w){1'b0}}, limit_q[slot]};
        end else if (is_ctrl) begin
            wb_dat_r = {{(data_w-1){1'b0}}, addr32_q};
        end
    end

    assign cfg = '{base: base_q, limit: limit_q, addr32: addr32_q};

endmodule

// File: hdl/addr_calc.sv
`timescale 1ns/1ps

module addr_calc (
    input  rrag_pkg::uop_t                 uop,
    input  logic [rrag_pkg::data_w-1:0]    base_val,
    input  logic [rrag_pkg::data_w-1:0]    index_val,
    input  rrag_pkg::seg_cfg_t             cfg,
    output logic [rrag_pkg::data_w-1:0]    lin_addr,
    output logic                           fault
);
    import rrag_pkg::*;

    logic [data_w-1:0] base_term;
    logic [data_w-1:0] index_term;
    logic [data_w-1:0] sum;
    logic [data_w-1:0] offset;
    logic [3:0]        len_m1;
    logic [data_w:0]   end_addr;
    logic [data_w:0]   lim_ext;

    always_comb begin
        base_term  = uop.use_base ? base_val : '0;
        index_term = uop.use_index ? (index_val << uop.scale) : '0;
        sum        = base_term + index_term + uop.disp;  // wraps modulo 2^32

        if (cfg.addr32) begin
            offset = sum;
        end else begin
            offset = {{(data_w-addr16_w){1'b0}}, sum[addr16_w-1:0]};
        end
    end

    // last byte touched by the access, relative to the segment
    always_comb begin
        case (uop.opsize)
            size_byte:  len_m1 = 4'd0;
            size_word:  len_m1 = 4'd1;
            size_dword: len_m1 = 4'd3;
            default:    len_m1 = 4'd7;
        endcase
    end

    assign end_addr = {1'b0, offset} + {{(data_w-3){1'b0}}, len_m1};
    assign lim_ext  = {{(data_w+1-limit_w){1'b0}}, cfg.limit[uop.seg]};
    assign fault    = (end_addr > lim_ext);  // compared in 33 bits so the carry counts

    assign lin_addr = cfg.base[uop.seg] + offset;

endmodule

// File: hdl/rrag_stage.sv
`timescale 1ns/1ps

module rrag_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  rrag_pkg::uop_t                 uop_in,
    output logic                           in_ready,
    input  logic                           rd_pend_a,
    input  logic                           rd_pend_b,
    input  logic [rrag_pkg::data_w-1:0]    base_val,
    input  logic [rrag_pkg::data_w-1:0]    index_val,
    input  logic [rrag_pkg::data_w-1:0]    lin_addr,
    input  logic                           fault,
    output logic                           mark_en,
    output logic [rrag_pkg::gpr_aw-1:0]    mark_addr,
    output rrag_pkg::agu_out_t             agu_out,
    input  logic                           out_ready
);
    import rrag_pkg::*;

    logic     hazard;
    logic     out_free;
    logic     accept;
    agu_out_t out_next;
    agu_out_t out_q;

    // only sources the micro-op really reads can hold it back
    assign hazard   = (uop_in.use_base & rd_pend_a) | (uop_in.use_index & rd_pend_b);
    assign out_free = ~out_q.valid | out_ready;  // empty or draining this cycle
    assign in_ready = out_free & ~hazard;
    assign accept   = uop_in.valid & in_ready;

    assign mark_en   = accept & uop_in.dest_ld;
    assign mark_addr = uop_in.dest_reg;

    always_comb begin
        out_next.valid     = 1'b1;
        out_next.base_val  = base_val;
        out_next.index_val = index_val;
        out_next.lin_addr  = lin_addr;
        out_next.fault     = fault;
        out_next.dest_reg  = uop_in.dest_reg;
        out_next.dest_ld   = uop_in.dest_ld;
        out_next.opsize    = uop_in.opsize;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_q <= '0;
        end else if (accept) begin
            out_q <= out_next;  // held unchanged until the next acceptance
        end else if (out_ready) begin
            out_q.valid <= 1'b0;
        end
    end

    assign agu_out = out_q;

endmodule

// File: hdl/rrag_top.sv
`timescale 1ns/1ps

module rrag_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [rrag_pkg::wb_aw-1:0]     wb_adr,
    input  logic [rrag_pkg::data_w-1:0]    wb_dat_w,
    output logic [rrag_pkg::data_w-1:0]    wb_dat_r,
    output logic                           wb_ack,
    input  rrag_pkg::uop_t                 uop_in,
    output logic                           in_ready,
    input  rrag_pkg::res_wr_t              res_wr,
    output rrag_pkg::agu_out_t             agu_out,
    input  logic                           out_ready
);
    import rrag_pkg::*;

    logic [data_w-1:0] rd_data_a;
    logic [data_w-1:0] rd_data_b;
    logic              rd_pend_a;
    logic              rd_pend_b;
    logic              mark_en;
    logic [gpr_aw-1:0] mark_addr;
    seg_cfg_t          cfg;
    logic [data_w-1:0] lin_addr;
    logic              fault;

    gpr_file u_gpr (
        .clk(clk), .arst_n(arst_n), .res_wr(res_wr),
        .rd_addr_a(uop_in.base_reg), .rd_addr_b(uop_in.index_reg),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .rd_pend_a(rd_pend_a), .rd_pend_b(rd_pend_b),
        .mark_en(mark_en), .mark_addr(mark_addr)
    );

    seg_cfg_regs u_cfg (
        .clk(clk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .cfg(cfg)
    );

    addr_calc u_agu (
        .uop(uop_in), .base_val(rd_data_a), .index_val(rd_data_b),
        .cfg(cfg), .lin_addr(lin_addr), .fault(fault)
    );

    rrag_stage u_stage (
        .clk(clk), .arst_n(arst_n), .uop_in(uop_in), .in_ready(in_ready),
        .rd_pend_a(rd_pend_a), .rd_pend_b(rd_pend_b),
        .base_val(rd_data_a), .index_val(rd_data_b),
        .lin_addr(lin_addr), .fault(fault),
        .mark_en(mark_en), .mark_addr(mark_addr),
        .agu_out(agu_out), .out_ready(out_ready)
    );

endmodule

// File: include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// each entry holds a name, the addressing mode, the sources, scale, segment, disp,
// operand size and the fault the limit rule predicts for it
typedef struct packed {
    logic [63:0]       name;
    logic              addr32;
    logic [gpr_aw-1:0] base_reg;
    logic [gpr_aw-1:0] index_reg;
    logic              use_base;
    logic              use_index;
    logic [1:0]        scale;
    seg_e              seg;
    logic [data_w-1:0] disp;
    opsize_e           opsize;
    logic              exp_fault;
} vec_t;

localparam int n_vec = 17;

// es has a limit of 0xfff, the other segments 0xfffff
localparam vec_t vectors [n_vec] = '{
    '{"s0_base", 1'b1, 3'd1, 3'd0, 1'b1, 1'b0, 2'd0, seg_ds, 32'h10, size_dword, 1'b0},
    '{"s1_idx", 1'b1, 3'd0, 3'd2, 1'b0, 1'b1, 2'd1, seg_ss, 32'h0, size_word, 1'b0},
    '{"s2_bi", 1'b1, 3'd3, 3'd4, 1'b1, 1'b1, 2'd2, seg_cs, 32'h100, size_byte, 1'b0},
    '{"s3_bi", 1'b1, 3'd5, 3'd6, 1'b1, 1'b1, 2'd3, seg_ds, 32'h40, size_qword, 1'b0},
    '{"s3_idx", 1'b1, 3'd0, 3'd7, 1'b0, 1'b1, 2'd3, seg_ss, 32'h0, size_dword, 1'b0},
    '{"disp_es", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'h200, size_byte, 1'b0},
    '{"w16_bi", 1'b0, 3'd1, 3'd2, 1'b1, 1'b1, 2'd0, seg_ds, 32'h0, size_word, 1'b0},
    '{"w16_disp", 1'b0, 3'd3, 3'd0, 1'b1, 1'b0, 2'd0, seg_cs, 32'hff00, size_byte, 1'b0},
    '{"w16_sc3", 1'b0, 3'd4, 3'd5, 1'b1, 1'b1, 2'd3, seg_ss, 32'h0, size_dword, 1'b0},
    '{"lim_b_ok", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'hfff, size_byte, 1'b0},
    '{"lim_b_ov", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'h1000, size_byte, 1'b1},
    '{"lim_w_ok", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'hffe, size_word, 1'b0},
    '{"lim_w_ov", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'hfff, size_word, 1'b1},
    '{"lim_d_ok", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'hffc, size_dword, 1'b0},
    '{"lim_d_ov", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'hffd, size_dword, 1'b1},
    '{"lim_q_ok", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'hff8, size_qword, 1'b0},
    '{"lim_q_ov", 1'b1, 3'd0, 3'd0, 1'b0, 1'b0, 2'd0, seg_es, 32'hff9, size_qword, 1'b1}
};

`endif

// File: test/rrag_tb.sv
`timescale 1ns/1ps

module rrag_tb;
    import rrag_pkg::*;

    `include "tb_vectors.svh"

    localparam int max_cycles = 20 * n_vec + 200;

    logic               clk;
    logic               arst_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [wb_aw-1:0]   wb_adr;
    logic [data_w-1:0]  wb_dat_w;
    logic [data_w-1:0]  wb_dat_r;
    logic               wb_ack;
    uop_t               uop_in;
    logic               in_ready;
    res_wr_t            res_wr;
    agu_out_t           agu_out;
    logic               out_ready;

    logic [data_w-1:0]  gpr_model [num_gpr];
    logic [data_w-1:0]  seg_base [num_seg];
    logic [limit_w-1:0] seg_lim [num_seg];
    logic               mode32;
    int                 cycles;

    rrag_top DUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("=== FAIL ===");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_eq(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // one classic cycle; ack must drop right after the cycle it was seen
    task automatic wb_access(input logic we, input logic [wb_aw-1:0] adr,
                             input logic [data_w-1:0] wdat, output logic [data_w-1:0] rdat);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        rdat = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_eq("wb_ack_one_cycle", 32'd0, {31'd0, wb_ack});
    endtask

    task automatic finish_accept();
        do begin
            @(negedge clk);
        end while (!in_ready);
        @(posedge clk);
        uop_in <= '0;  // accepted at this edge
    endtask

    task automatic send_uop(input uop_t u);
        @(posedge clk);
        uop_in <= u;
        finish_accept();
    endtask

    // returns {fault, linear address}
    function automatic logic [data_w:0] ref_addr(input vec_t v, input logic [data_w-1:0] bv,
                                                 input logic [data_w-1:0] iv);
        logic [data_w-1:0] off;
        logic [data_w:0]   last;
        off = v.disp;
        if (v.use_base) begin
            off = off + bv;
        end
        if (v.use_index) begin
            off = off + (iv << v.scale);
        end
        if (!v.addr32) begin
            off = off & 32'h0000_ffff;
        end
        last = {1'b0, off} + (33'd1 << v.opsize) - 33'd1;
        return {last > {13'd0, seg_lim[v.seg]}, seg_base[v.seg] + off};
    endfunction

    initial begin
        vec_t              v;
        uop_t              u;
        logic [data_w:0]   exp_v;
        logic [data_w-1:0] rd;
        logic [data_w-1:0] hz_data;
        string             tname;

        clk       = 1'b0;
        arst_n    = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        uop_in    = '0;
        res_wr    = '0;
        out_ready = 1'b1;
        cycles    = 0;
        void'($urandom(16));

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_eq("reset_in_ready", 32'd1, {31'd0, in_ready});
        check_eq("reset_out_valid", 32'd0, {31'd0, agu_out.valid});

        for (int s = 0; s < num_seg; s++) begin
            seg_base[s] = {4'(s + 1), 28'h000_0100};
            seg_lim[s]  = (s == 0) ? 20'h00fff : 20'hfffff;
            wb_access(1'b1, 4'(s), seg_base[s], rd);
            wb_access(1'b1, 4'(s + 4), 32'ha5a0_0000 | {12'd0, seg_lim[s]}, rd);
        end
        wb_access(1'b0, wb_ctrl_addr, 32'd0, rd);
        check_eq("ctrl_reset_value", 32'd1, rd);
        wb_access(1'b1, wb_ctrl_addr, 32'd0, rd);
        wb_access(1'b0, wb_ctrl_addr, 32'd0, rd);
        check_eq("ctrl_readback", 32'd0, rd);
        wb_access(1'b1, wb_ctrl_addr, 32'd1, rd);
        mode32 = 1'b1;
        for (int s = 0; s < num_seg; s++) begin
            wb_access(1'b0, 4'(s), 32'd0, rd);
            check_eq("base_readback", seg_base[s], rd);
            wb_access(1'b0, 4'(s + 4), 32'd0, rd);
            check_eq("limit_readback", {12'd0, seg_lim[s]}, rd);  // upper bits dropped
        end
        wb_access(1'b1, 4'd9, 32'hffff_ffff, rd);
        wb_access(1'b0, 4'd9, 32'd0, rd);
        check_eq("unmapped_read", 32'd0, rd);

        // values in 0x8000..0xffff so base plus index always carries out of 16 bits
        for (int r = 0; r < num_gpr; r++) begin
            gpr_model[r] = ($urandom & 32'h0000_7fff) | 32'h0000_8000;
            @(posedge clk);
            res_wr <= '{1'b1, 3'(r), gpr_model[r]};
        end
        @(posedge clk);
        res_wr <= '0;

        for (int k = 0; k < n_vec; k++) begin
            v     = vectors[k];
            tname = $sformatf("%s", v.name);
            if (v.addr32 != mode32) begin
                wb_access(1'b1, wb_ctrl_addr, {31'd0, v.addr32}, rd);
                mode32 = v.addr32;
            end
            u           = '0;
            u.valid     = 1'b1;
            u.base_reg  = v.base_reg;
            u.index_reg = v.index_reg;
            u.use_base  = v.use_base;
            u.use_index = v.use_index;
            u.scale     = v.scale;
            u.seg       = v.seg;
            u.disp      = v.disp;
            u.opsize    = v.opsize;
            exp_v = ref_addr(v, gpr_model[v.base_reg], gpr_model[v.index_reg]);
            send_uop(u);
            @(negedge clk);
            check_eq({tname, "_valid"}, 32'd1, {31'd0, agu_out.valid});
            check_eq(tname, exp_v[data_w-1:0], agu_out.lin_addr);
            check_eq({tname, "_index_val"}, gpr_model[v.index_reg], agu_out.index_val);
            check_eq({tname, "_opsize"}, {30'd0, v.opsize}, {30'd0, agu_out.opsize});
            check_eq({tname, "_fault"}, {31'd0, v.exp_fault}, {31'd0, agu_out.fault});
            check_eq({tname, "_ref_fault"}, {31'd0, v.exp_fault}, {31'd0, exp_v[data_w]});
        end

        // r3 becomes pending, r2 stays free
        u          = '0;
        u.valid    = 1'b1;
        u.seg      = seg_ds;
        u.opsize   = size_dword;
        u.dest_reg = 3'd3;
        u.dest_ld  = 1'b1;
        send_uop(u);
        @(negedge clk);
        check_eq("dest_reg", 32'd3, {29'd0, agu_out.dest_reg});
        check_eq("dest_ld", 32'd1, {31'd0, agu_out.dest_ld});
        u.dest_ld   = 1'b0;
        u.use_base  = 1'b1;
        u.base_reg  = 3'd2;
        u.index_reg = 3'd3;  // named but not used, so it must not stall
        @(posedge clk);
        uop_in <= u;
        @(negedge clk);
        check_eq("no_stall_ready", 32'd1, {31'd0, in_ready});
        @(posedge clk);
        uop_in <= '0;
        @(negedge clk);
        check_eq("no_stall_base_val", gpr_model[2], agu_out.base_val);

        u.base_reg = 3'd3;
        @(posedge clk);
        uop_in <= u;
        repeat (3) begin
            @(negedge clk);
            check_eq("hazard_stall", 32'd0, {31'd0, in_ready});
        end
        hz_data      = $urandom;
        gpr_model[3] = hz_data;
        @(posedge clk);
        res_wr <= '{1'b1, 3'd3, hz_data};
        @(posedge clk);
        res_wr <= '0;
        finish_accept();
        @(negedge clk);
        check_eq("hazard_base_val", hz_data, agu_out.base_val);
        check_eq("hazard_lin_addr", seg_base[seg_ds] + hz_data, agu_out.lin_addr);

        @(posedge clk);
        out_ready <= 1'b0;
        u        = '0;
        u.valid  = 1'b1;
        u.seg    = seg_ds;
        u.opsize = size_byte;
        u.disp   = 32'h0000_0010;
        send_uop(u);
        u.disp = 32'h0000_0020;
        @(posedge clk);
        uop_in <= u;
        repeat (3) begin
            @(negedge clk);
            check_eq("bp_ready_low", 32'd0, {31'd0, in_ready});
            check_eq("bp_held_valid", 32'd1, {31'd0, agu_out.valid});
            check_eq("bp_held_addr", seg_base[seg_ds] + 32'h10, agu_out.lin_addr);
        end
        @(posedge clk);
        out_ready <= 1'b1;
        @(negedge clk);
        check_eq("bp_first", seg_base[seg_ds] + 32'h10, agu_out.lin_addr);
        check_eq("bp_ready_again", 32'd1, {31'd0, in_ready});
        @(posedge clk);
        uop_in <= '0;
        @(negedge clk);
        check_eq("bp_second_valid", 32'd1, {31'd0, agu_out.valid});
        check_eq("bp_second", seg_base[seg_ds] + 32'h20, agu_out.lin_addr);
        @(posedge clk);
        @(negedge clk);
        check_eq("bp_no_duplicate", 32'd0, {31'd0, agu_out.valid});

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
hdl/rrag_pkg.sv
hdl/gpr_file.sv
hdl/seg_cfg_regs.sv
hdl/addr_calc.sv
hdl/rrag_stage.sv
hdl/rrag_top.sv
test/rrag_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rrag_tb -f compile.f -o rrag_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/rrag_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
